/* common/axi_rd_pkg.sv */
//////////////////////////////////////////////////////////////////////
// AXI read channel types
//////////////////////////////////////////////////////////////////////

`include "ser_defs.svh"

package axi_rd_pkg;

  // Master-port ID is just the slot index
  localparam int unsigned MST_ID_W = $clog2(`SER_NUM_SLOTS);

  typedef logic [`SER_ADDR_W-1:0]   addr_t;
  typedef logic [`SER_DATA_W-1:0]   data_t;
  typedef logic [`SER_LEN_W-1:0]    len_t;
  typedef logic [`SER_SLV_ID_W-1:0] slv_id_t;
  typedef logic [MST_ID_W-1:0]      mst_id_t;

  typedef struct packed {
    slv_id_t id;
    addr_t   addr;
    len_t    len;
  } ar_slv_t;

  typedef struct packed {
    mst_id_t id;
    addr_t   addr;
    len_t    len;
  } ar_mst_t;

  typedef struct packed {
    slv_id_t id;
    data_t   data;
    logic    last;
  } r_slv_t;

  typedef struct packed {
    mst_id_t id;
    data_t   data;
    logic    last;
  } r_mst_t;

endpackage

/* common/id_map_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Slot mapping types
//////////////////////////////////////////////////////////////////////

`include "ser_defs.svh"

package id_map_pkg;

  localparam int unsigned SLOT_IDX_W = $clog2(`SER_NUM_SLOTS);
  localparam int unsigned SLOT_CNT_W = $clog2(`SER_TXNS_PER_ID + 1);

  // Slot number, doubles as the master-port ID
  typedef logic [SLOT_IDX_W-1:0] slot_idx_t;

  // Outstanding transactions in one slot, 0 up to the limit
  typedef logic [SLOT_CNT_W-1:0] slot_cnt_t;

  localparam slot_cnt_t SLOT_CNT_MAX = slot_cnt_t'(`SER_TXNS_PER_ID);

endpackage

/* common/ser_defs.svh */
//////////////////////////////////////////////////////////////////////
// Read ID serializer widths
//////////////////////////////////////////////////////////////////////

`ifndef SER_DEFS_SVH
`define SER_DEFS_SVH

// Bus widths
`define SER_ADDR_W 32
`define SER_DATA_W 32
`define SER_LEN_W 8

// Slave-port ID space and slot organisation
`define SER_SLV_ID_W 6
`define SER_NUM_SLOTS 4
`define SER_TXNS_PER_ID 4

`endif

/* files.f */
+incdir+common
common/axi_rd_pkg.sv
common/id_map_pkg.sv
id_serialize/ar_slot_demux.sv
id_serialize/rd_serializer.sv
id_serialize/ar_slot_arbiter.sv
id_serialize/axi_rd_id_serialize.sv
test/rd_slave_model.sv
test/tb_axi_rd_id_serialize.sv

/* id_serialize/ar_slot_arbiter.sv */
//////////////////////////////////////////////////////////////////////
// Slot arbiter and R steering
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "ser_defs.svh"

module ar_slot_arbiter (
  input  logic                                           clk_i,
  input  logic                                           rst_i,
  input  axi_rd_pkg::ar_slv_t [`SER_NUM_SLOTS-1:0] slot_ar_i,
  input  logic                [`SER_NUM_SLOTS-1:0] slot_ar_valid_i,
  output logic                [`SER_NUM_SLOTS-1:0] slot_ar_ready_o,
  output axi_rd_pkg::ar_mst_t                      mst_ar_o,
  output logic                                     mst_ar_valid_o,
  input  logic                                     mst_ar_ready_i,
  input  axi_rd_pkg::r_mst_t                       mst_r_i,
  input  logic                                     mst_r_valid_i,
  output logic                                     mst_r_ready_o,
  output logic                [`SER_NUM_SLOTS-1:0] slot_r_valid_o,
  input  logic                [`SER_NUM_SLOTS-1:0] slot_r_ready_i
);

  import axi_rd_pkg::*;
  import id_map_pkg::*;

  slot_idx_t rr_q;
  slot_idx_t grant_q;
  logic      hold_q;
  slot_idx_t pick;
  slot_idx_t sel;
  logic      ar_fire;

  // Round-robin search starting at the pointer
  always_comb begin
    slot_idx_t idx;
    logic      found;
    pick  = rr_q;
    found = 1'b0;
    for (int i = 0; i < `SER_NUM_SLOTS; i++) begin
      idx = slot_idx_t'((int'(rr_q) + i) % `SER_NUM_SLOTS);
      if (!found && slot_ar_valid_i[idx]) begin
        pick  = idx;
        found = 1'b1;
      end
    end
  end

  // A stalled request keeps its grant
  assign sel = hold_q ? grant_q : pick;

  always_comb begin
    mst_ar_o.id          = mst_id_t'(sel);
    mst_ar_o.addr        = slot_ar_i[sel].addr;
    mst_ar_o.len         = slot_ar_i[sel].len;
    mst_ar_valid_o       = slot_ar_valid_i[sel];
    slot_ar_ready_o      = '0;
    slot_ar_ready_o[sel] = mst_ar_ready_i;
  end

  assign ar_fire = mst_ar_valid_o && mst_ar_ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rr_q    <= '0;
      grant_q <= '0;
      hold_q  <= 1'b0;
    end else if (ar_fire) begin
      hold_q <= 1'b0;
      rr_q   <= slot_idx_t'((int'(sel) + 1) % `SER_NUM_SLOTS);
    end else if (mst_ar_valid_o) begin
      hold_q  <= 1'b1;
      grant_q <= sel;
    end
  end

  // R id names the slot directly
  always_comb begin
    slot_r_valid_o             = '0;
    slot_r_valid_o[mst_r_i.id] = mst_r_valid_i;
    mst_r_ready_o              = slot_r_ready_i[mst_r_i.id];
  end

  a_ar_stable : assert property (@(posedge clk_i) disable iff (rst_i)
    mst_ar_valid_o && !mst_ar_ready_i |=> mst_ar_valid_o && $stable(mst_ar_o));

endmodule

/* id_serialize/ar_slot_demux.sv */
//////////////////////////////////////////////////////////////////////
// AR spill register and slot steering
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "ser_defs.svh"

module ar_slot_demux (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  axi_rd_pkg::ar_slv_t       slv_ar_i,
  input  logic                      slv_ar_valid_i,
  output logic                      slv_ar_ready_o,
  output axi_rd_pkg::ar_slv_t       slot_ar_o,
  output logic [`SER_NUM_SLOTS-1:0] slot_ar_valid_o,
  input  logic [`SER_NUM_SLOTS-1:0] slot_ar_ready_i
);

  import axi_rd_pkg::*;
  import id_map_pkg::*;

  ar_slv_t   ar_q;
  logic      full_q;
  slot_idx_t sel;
  logic      in_fire;
  logic      out_fire;

  // Slot follows from the registered ID
  assign sel       = slot_idx_t'(ar_q.id % `SER_NUM_SLOTS);
  assign slot_ar_o = ar_q;

  always_comb begin
    slot_ar_valid_o      = '0;
    slot_ar_valid_o[sel] = full_q;
  end

  assign out_fire       = full_q && slot_ar_ready_i[sel];
  // Accept when empty or draining this cycle
  assign slv_ar_ready_o = !full_q || out_fire;
  assign in_fire        = slv_ar_valid_i && slv_ar_ready_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      full_q <= 1'b0;
    end else if (in_fire) begin
      full_q <= 1'b1;
    end else if (out_fire) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_fire) begin
      ar_q <= slv_ar_i;
    end
  end

  // The source keeps a stalled request steady until it is taken
  a_in_stable : assert property (@(posedge clk_i) disable iff (rst_i)
    slv_ar_valid_i && !slv_ar_ready_o |=> slv_ar_valid_i && $stable(slv_ar_i));

endmodule

/* id_serialize/axi_rd_id_serialize.sv */
//////////////////////////////////////////////////////////////////////
// AXI read ID serializer
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "ser_defs.svh"

module axi_rd_id_serialize (
  input  logic                clk_i,
  input  logic                rst_i,
  input  axi_rd_pkg::ar_slv_t slv_ar_i,
  input  logic                slv_ar_valid_i,
  output logic                slv_ar_ready_o,
  output axi_rd_pkg::r_slv_t  slv_r_o,
  output logic                slv_r_valid_o,
  input  logic                slv_r_ready_i,
  output axi_rd_pkg::ar_mst_t mst_ar_o,
  output logic                mst_ar_valid_o,
  input  logic                mst_ar_ready_i,
  input  axi_rd_pkg::r_mst_t  mst_r_i,
  input  logic                mst_r_valid_i,
  output logic                mst_r_ready_o
);

  import axi_rd_pkg::*;

  ar_slv_t                       demux_ar;
  logic [`SER_NUM_SLOTS-1:0]     demux_ar_valid;
  logic [`SER_NUM_SLOTS-1:0]     demux_ar_ready;
  ar_slv_t [`SER_NUM_SLOTS-1:0]  req;
  logic [`SER_NUM_SLOTS-1:0]     req_valid;
  logic [`SER_NUM_SLOTS-1:0]     req_ready;
  logic [`SER_NUM_SLOTS-1:0]     slot_r_valid;
  logic [`SER_NUM_SLOTS-1:0]     slot_r_ready;
  r_slv_t [`SER_NUM_SLOTS-1:0]   ser_r;
  logic [`SER_NUM_SLOTS-1:0]     ser_r_valid;

  ar_slot_demux i_demux (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .slv_ar_i        (slv_ar_i),
    .slv_ar_valid_i  (slv_ar_valid_i),
    .slv_ar_ready_o  (slv_ar_ready_o),
    .slot_ar_o       (demux_ar),
    .slot_ar_valid_o (demux_ar_valid),
    .slot_ar_ready_i (demux_ar_ready)
  );

  for (genvar i = 0; i < `SER_NUM_SLOTS; i++) begin : gen_slot
    rd_serializer i_ser (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .ar_i        (demux_ar),
      .ar_valid_i  (demux_ar_valid[i]),
      .ar_ready_o  (demux_ar_ready[i]),
      .req_o       (req[i]),
      .req_valid_o (req_valid[i]),
      .req_ready_i (req_ready[i]),
      .r_i         (mst_r_i),
      .r_valid_i   (slot_r_valid[i]),
      .r_ready_o   (slot_r_ready[i]),
      .r_o         (ser_r[i]),
      .r_valid_o   (ser_r_valid[i]),
      .r_ready_i   (slv_r_ready_i)
    );
  end

  ar_slot_arbiter i_arb (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .slot_ar_i       (req),
    .slot_ar_valid_i (req_valid),
    .slot_ar_ready_o (req_ready),
    .mst_ar_o        (mst_ar_o),
    .mst_ar_valid_o  (mst_ar_valid_o),
    .mst_ar_ready_i  (mst_ar_ready_i),
    .mst_r_i         (mst_r_i),
    .mst_r_valid_i   (mst_r_valid_i),
    .mst_r_ready_o   (mst_r_ready_o),
    .slot_r_valid_o  (slot_r_valid),
    .slot_r_ready_i  (slot_r_ready)
  );

  // At most one slot carries a beat, so a plain OR merges them
  always_comb begin
    slv_r_o       = '0;
    slv_r_valid_o = 1'b0;
    for (int i = 0; i < `SER_NUM_SLOTS; i++) begin
      if (ser_r_valid[i]) begin
        slv_r_o = r_slv_t'(slv_r_o | ser_r[i]);
      end
      slv_r_valid_o = slv_r_valid_o | ser_r_valid[i];
    end
  end

endmodule

/* id_serialize/rd_serializer.sv */
//////////////////////////////////////////////////////////////////////
// Per-slot read serializer
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module rd_serializer (
  input  logic                clk_i,
  input  logic                rst_i,
  // Request from the demux
  input  axi_rd_pkg::ar_slv_t ar_i,
  input  logic                ar_valid_i,
  output logic                ar_ready_o,
  // Request towards the arbiter
  output axi_rd_pkg::ar_slv_t req_o,
  output logic                req_valid_o,
  input  logic                req_ready_i,
  // Response from the master port
  input  axi_rd_pkg::r_mst_t  r_i,
  input  logic                r_valid_i,
  output logic                r_ready_o,
  // Response towards the slave port
  output axi_rd_pkg::r_slv_t  r_o,
  output logic                r_valid_o,
  input  logic                r_ready_i
);

  import axi_rd_pkg::*;
  import id_map_pkg::*;

  slv_id_t   lock_id_q;
  slot_cnt_t cnt_q;
  slot_cnt_t cnt_d;
  logic      id_match;
  logic      admit;
  logic      req_fire;
  logic      r_done;

  // The ID stays locked while the count is nonzero
  assign id_match = (ar_i.id == lock_id_q);

  // Free slot, or same ID with room for one more
  assign admit = (cnt_q == '0) || (id_match && (cnt_q < SLOT_CNT_MAX));

  assign req_o       = ar_i;
  assign req_valid_o = ar_valid_i && admit;
  assign ar_ready_o  = req_ready_i && admit;

  assign req_fire = req_valid_o && req_ready_i;
  assign r_done   = r_valid_i && r_ready_i && r_i.last;

  // Restore the slave ID on the way back
  always_comb begin
    r_o.id   = lock_id_q;
    r_o.data = r_i.data;
    r_o.last = r_i.last;
  end

  assign r_valid_o = r_valid_i;
  assign r_ready_o = r_ready_i;

  always_comb begin
    cnt_d = cnt_q;
    if (req_fire && !r_done) begin
      cnt_d = cnt_q + 1'b1;
    end else if (!req_fire && r_done) begin
      cnt_d = cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      lock_id_q <= ar_i.id;
    end
  end

  a_cnt_limit : assert property (@(posedge clk_i) disable iff (rst_i)
    cnt_q <= SLOT_CNT_MAX);

  // A beat for this slot needs a request that went out earlier
  a_r_has_txn : assert property (@(posedge clk_i) disable iff (rst_i)
    r_valid_i |-> (cnt_q != '0));

endmodule

/* test/rd_slave_model.sv */
//////////////////////////////////////////////////////////////////////
// AXI read memory model
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module rd_slave_model (
  input  logic                clk_i,
  input  logic                rst_i,
  input  axi_rd_pkg::ar_mst_t ar_i,
  input  logic                ar_valid_i,
  output logic                ar_ready_o,
  output axi_rd_pkg::r_mst_t  r_o,
  output logic                r_valid_o,
  input  logic                r_ready_i,
  // Random back-pressure and beat gaps
  input  logic                ar_stall_i,
  input  logic                r_stall_i
);

  import axi_rd_pkg::*;

  ar_mst_t pend_q[$];
  ar_mst_t ar_in;
  int      beat;
  logic    ar_take;
  logic    r_take;
  logic    stall;

  assign ar_ready_o = !ar_stall_i;

  initial begin
    r_o       = '0;
    r_valid_o = 1'b0;
    beat      = 0;
  end

  always @(posedge clk_i) begin
    ar_take = ar_valid_i && ar_ready_o && !rst_i;
    r_take  = r_valid_o && r_ready_i;
    ar_in   = ar_i;
    stall   = r_stall_i;
    #1;
    if (ar_take) begin
      pend_q.push_back(ar_in);
    end
    // Requests are answered strictly in order
    if (r_take) begin
      if (beat == int'(pend_q[0].len)) begin
        void'(pend_q.pop_front());
        beat = 0;
      end else begin
        beat++;
      end
    end
    // A raised valid stays until its beat is taken
    if (!r_valid_o || r_take) begin
      r_valid_o = (pend_q.size() > 0) && !stall;
      if (r_valid_o) begin
        r_o.id   = pend_q[0].id;
        r_o.data = pend_q[0].addr + data_t'(beat);
        r_o.last = (beat == int'(pend_q[0].len));
      end
    end
  end

endmodule

/* test/tb_axi_rd_id_serialize.sv */
//////////////////////////////////////////////////////////////////////
// Read ID serializer testbench
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "ser_defs.svh"

module tb_axi_rd_id_serialize;

  import axi_rd_pkg::*;

  localparam int NUM_REQ   = 200;
  localparam int MAX_BEATS = 4;
  localparam int TIMEOUT   = NUM_REQ * MAX_BEATS * 8;
  localparam int NS        = `SER_NUM_SLOTS;

  logic        clk;
  logic        rst;
  ar_slv_t     slv_ar;
  logic        slv_ar_valid;
  logic        slv_ar_ready;
  r_slv_t      slv_r;
  logic        slv_r_valid;
  logic        slv_r_ready;
  ar_mst_t     mst_ar;
  logic        mst_ar_valid;
  logic        mst_ar_ready;
  r_mst_t      mst_r;
  logic        mst_r_valid;
  logic        mst_r_ready;
  logic        ar_stall;
  logic        r_stall;
  logic        ar_taken;
  logic [31:0] lfsr_q;
  int          sent;
  int          done_cnt;
  int          cycles;
  int          beat_cnt;

  // Expected traffic, per slot before the master port and in issue order after it
  ar_slv_t                 slot_q[NS][$];
  ar_slv_t                 issued_q[$];
  ar_slv_t [NS-1:0]        exp_ar;
  logic [NS-1:0]           exp_ar_vld;
  logic [NS-1:0][3:0]      out_cnt;
  slv_id_t [NS-1:0]        out_id;
  r_slv_t                  exp_r;
  logic                    exp_r_vld;
  ar_slv_t                 ar_exp;
  logic [3:0]              cnt_at_mst;
  slv_id_t                 id_at_mst;
  logic                    mst_fire;
  logic                    slv_r_fire;

  axi_rd_id_serialize DUT (
    .clk_i          (clk),
    .rst_i          (rst),
    .slv_ar_i       (slv_ar),
    .slv_ar_valid_i (slv_ar_valid),
    .slv_ar_ready_o (slv_ar_ready),
    .slv_r_o        (slv_r),
    .slv_r_valid_o  (slv_r_valid),
    .slv_r_ready_i  (slv_r_ready),
    .mst_ar_o       (mst_ar),
    .mst_ar_valid_o (mst_ar_valid),
    .mst_ar_ready_i (mst_ar_ready),
    .mst_r_i        (mst_r),
    .mst_r_valid_i  (mst_r_valid),
    .mst_r_ready_o  (mst_r_ready)
  );

  rd_slave_model i_mem (
    .clk_i      (clk),
    .rst_i      (rst),
    .ar_i       (mst_ar),
    .ar_valid_i (mst_ar_valid),
    .ar_ready_o (mst_ar_ready),
    .r_o        (mst_r),
    .r_valid_o  (mst_r_valid),
    .r_ready_i  (mst_r_ready),
    .ar_stall_i (ar_stall),
    .r_stall_i  (r_stall)
  );

  assign mst_fire   = mst_ar_valid && mst_ar_ready;
  assign slv_r_fire = slv_r_valid && slv_r_ready;
  assign ar_exp     = exp_ar[mst_ar.id];
  assign cnt_at_mst = out_cnt[mst_ar.id];
  assign id_at_mst  = out_id[mst_ar.id];

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      val    = {val[30:0], fb};
    end
    return val;
  endfunction

  task automatic abort_run();
    $display("*** FAILED ***");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic show_mismatch(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    $display("Error at %0t: %s = %0h, expected %0h", $time, name, got, exp);
    abort_run();
  endtask

  task automatic explain_failure(input string msg);
    $display("%0t: %s", $time, msg);
    abort_run();
  endtask

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    lfsr_q       = 32'h4ebf5598;
    rst          = 1'b1;
    slv_ar       = '0;
    slv_ar_valid = 1'b0;
    slv_r_ready  = 1'b0;
    ar_stall     = 1'b0;
    r_stall      = 1'b0;
    sent         = 0;
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    forever begin
      @(posedge clk);
      ar_taken = slv_ar_valid && slv_ar_ready;
      #1;
      if (ar_taken) begin
        slv_ar_valid = 1'b0;
        sent++;
      end
      if (!slv_ar_valid && sent < NUM_REQ && rand_bits(2) != 0) begin
        // Eight IDs, two of them in each slot
        slv_ar.id    = slv_id_t'(rand_bits(3) * 5);
        slv_ar.addr  = rand_bits(32);
        slv_ar.len   = len_t'(rand_bits(2));
        slv_ar_valid = 1'b1;
      end
      slv_r_ready = (rand_bits(2) != 0);
      ar_stall    = (rand_bits(2) == 0);
      r_stall     = (rand_bits(2) == 0);
    end
  end

  // Scoreboard update on handshakes seen at the edge
  always @(posedge clk) begin
    ar_slv_t req;
    if (rst) begin
      beat_cnt = 0;
      done_cnt = 0;
      out_cnt  = '0;
      out_id   = '0;
    end else begin
      if (slv_ar_valid && slv_ar_ready) begin
        slot_q[slv_ar.id % NS].push_back(slv_ar);
      end
      if (mst_fire && slot_q[mst_ar.id].size() > 0) begin
        req = slot_q[mst_ar.id].pop_front();
        issued_q.push_back(req);
        out_cnt[mst_ar.id] = out_cnt[mst_ar.id] + 1'b1;
        out_id[mst_ar.id]  = req.id;
      end
      if (slv_r_fire && issued_q.size() > 0) begin
        if (beat_cnt == int'(issued_q[0].len)) begin
          req = issued_q.pop_front();
          out_cnt[req.id % NS] = out_cnt[req.id % NS] - 1'b1;
          beat_cnt = 0;
          done_cnt++;
        end else begin
          beat_cnt++;
        end
      end
    end
    for (int k = 0; k < NS; k++) begin
      exp_ar_vld[k] = (slot_q[k].size() > 0);
      exp_ar[k]     = exp_ar_vld[k] ? slot_q[k][0] : '0;
    end
    exp_r_vld = (issued_q.size() > 0);
    exp_r     = '0;
    if (exp_r_vld) begin
      exp_r.id   = issued_q[0].id;
      exp_r.data = issued_q[0].addr + data_t'(beat_cnt);
      exp_r.last = (beat_cnt == int'(issued_q[0].len));
    end
  end

  a_ar_pending : assert property (@(posedge clk) disable iff (rst)
    mst_fire |-> exp_ar_vld[mst_ar.id])
    else explain_failure("Master AR issued with no slave request waiting in its slot");

  // Address and length must belong to the oldest request of that slot
  a_ar_payload : assert property (@(posedge clk) disable iff (rst)
    mst_fire |-> {mst_ar.addr, mst_ar.len} == {ar_exp.addr, ar_exp.len})
    else show_mismatch("mst_ar_o", {$sampled(mst_ar.addr), $sampled(mst_ar.len)},
                       {$sampled(ar_exp.addr), $sampled(ar_exp.len)});

  a_r_pending : assert property (@(posedge clk) disable iff (rst)
    slv_r_fire |-> exp_r_vld)
    else explain_failure("Slave R beat returned with no request outstanding");

  a_r_beat : assert property (@(posedge clk) disable iff (rst)
    slv_r_fire |-> slv_r == exp_r)
    else show_mismatch("slv_r_o", $sampled(slv_r), $sampled(exp_r));

  a_slot_lock : assert property (@(posedge clk) disable iff (rst)
    mst_fire |-> (cnt_at_mst == 0) || (id_at_mst == ar_exp.id))
    else show_mismatch("mst_ar_o slave ID", $sampled(ar_exp.id), $sampled(id_at_mst));

  a_slot_depth : assert property (@(posedge clk) disable iff (rst)
    mst_fire |-> cnt_at_mst < `SER_TXNS_PER_ID)
    else explain_failure("Too many requests outstanding on one master ID");

  initial begin
    cycles = 0;
    @(negedge rst);
    while (done_cnt < NUM_REQ && cycles < TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    if (done_cnt == NUM_REQ) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      explain_failure($sformatf("Timeout with %0d of %0d requests complete",
                                done_cnt, NUM_REQ));
    end
  end

endmodule
